//--- Bender.yml
package:
  name: wb_dcache

sources:
  - cache_cfg_pkg.sv
  - mem_bus_pkg.sv
  - cache_way.sv
  - hit_select.sv
  - cache_ctrl.sv
  - cache_top.sv
  - target: test
    files:
      - cache_checker.sv
      - tb_cache_top.sv

//--- cache_cfg_pkg.sv
package cache_cfg_pkg;

  // address split is tag | index | word | byte, 21 + 5 + 3 + 3 bits.
  localparam int OFFSET_BITS    = 3;
  localparam int WORD_BITS      = 3;
  localparam int INDEX_BITS     = 5;
  localparam int TAG_BITS       = 32 - INDEX_BITS - WORD_BITS - OFFSET_BITS;
  localparam int NUM_SETS       = 1 << INDEX_BITS;
  localparam int WORDS_PER_LINE = 1 << WORD_BITS;

  typedef logic [31:0]             addr_t;
  typedef logic [TAG_BITS-1:0]     tag_t;
  typedef logic [INDEX_BITS-1:0]   index_t;
  typedef logic [WORD_BITS-1:0]    word_sel_t;
  typedef logic [OFFSET_BITS-1:0]  byte_off_t;
  typedef logic [63:0]             word_t;
  typedef logic [7:0]              strb_t;
  typedef logic [1:0]              size_t;

  typedef struct packed {
    addr_t addr;
    logic  we;
    size_t size;
    word_t wdata;
  } cpu_req_t;

  typedef struct packed {
    word_t rdata;
  } cpu_rsp_t;

  typedef struct packed {
    logic hit;
    logic valid;
    logic dirty;
    tag_t tag;
  } way_stat_t;

  // a word write happens whenever strb is non-zero.
  typedef struct packed {
    logic      set_dirty;
    logic      install;
    logic      validate;
    index_t    index;
    word_sel_t word_sel;
    strb_t     strb;
    word_t     wdata;
  } way_cmd_t;

  function automatic strb_t size_strb(size_t size);
    case (size)
      2'd0:    return 8'h01;
      2'd1:    return 8'h03;
      2'd2:    return 8'h0f;
      default: return 8'hff;
    endcase
  endfunction

  function automatic word_t strb_to_mask(strb_t strb);
    word_t mask;
    for (int b = 0; b < $bits(strb_t); b++) begin
      mask[8*b +: 8] = {8{strb[b]}};
    end
    return mask;
  endfunction

endpackage

//--- cache_checker.sv
`timescale 1ns/1ps

module cache_checker
  import cache_cfg_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  cpu_req_t req_i,
  input  logic     req_valid_i,
  input  logic     req_ready_i,
  input  cpu_rsp_t rsp_i,
  input  logic     rsp_valid_i,
  input  logic     rsp_ready_i,
  input  mem_req_t mem_req_i,
  input  logic     mem_req_valid_i,
  input  logic     mem_req_ready_i,
  input  word_t    mem_wdata_i,
  input  logic     mem_wvalid_i,
  input  logic     mem_wready_i,
  input  logic     mem_rready_i,
  input  int       test_id_i,
  input  int       exp_rd_i,
  input  int       exp_wr_i,
  output int       tests_o,
  output int       errors_o
);

  logic [7:0] shadow [addr_t];
  cpu_req_t   cur_req;
  int         cur_id;
  int         cur_exp_rd;
  int         cur_exp_wr;
  int         rd_bursts;
  int         wr_bursts;
  int         test_errors;
  int         wb_beat;
  addr_t      wb_base;
  logic       after_reset;

  initial begin
    tests_o  = 0;
    errors_o = 0;
  end

  // byte a of the background sits in the word at a with the low three bits cleared.
  function automatic logic [7:0] shadow_byte(addr_t a);
    addr_t wa;
    word_t pat;
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    wa  = {a[31:3], 3'b000};
    pat = {wa, ~wa};
    return pat[8 * a[2:0] +: 8];
  endfunction

  // bytes from a upward, lowest address in bits 7..0, zero above the size.
  function automatic word_t expected_data(addr_t a, size_t size);
    word_t v;
    v = '0;
    for (int i = 0; i < (1 << size); i++) begin
      v[8*i +: 8] = shadow_byte(a + addr_t'(i));
    end
    return v;
  endfunction

  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors_o++;
      test_errors++;
    end
  endtask

  task automatic finish_test();
    if (cur_req.we) begin
      for (int i = 0; i < (1 << cur_req.size); i++) begin
        shadow[cur_req.addr + addr_t'(i)] = cur_req.wdata[8*i +: 8];
      end
    end else begin
      check_value("rsp_o.rdata", rsp_i.rdata, expected_data(cur_req.addr, cur_req.size));
    end
    check_value("read bursts", word_t'(rd_bursts), word_t'(cur_exp_rd));
    check_value("write bursts", word_t'(wr_bursts), word_t'(cur_exp_wr));
    tests_o++;
    $display("test %0d: %s of %0d bytes at %h, %0d read and %0d write bursts, %s",
             cur_id, cur_req.we ? "write" : "read", 1 << cur_req.size, cur_req.addr,
             rd_bursts, wr_bursts, (test_errors == 0) ? "ok" : "mismatch");
  endtask

  always @(posedge clk) begin
    if (rst) begin
      shadow.delete();
      after_reset = 1'b1;
      wb_beat     = 0;
    end else begin
      if (after_reset) begin
        check_value("req_ready_o", word_t'(req_ready_i), 64'd1);
        check_value("rsp_valid_o", word_t'(rsp_valid_i), 64'd0);
        check_value("mem_req_valid_o", word_t'(mem_req_valid_i), 64'd0);
        check_value("mem_wvalid_o", word_t'(mem_wvalid_i), 64'd0);
        check_value("mem_rready_o", word_t'(mem_rready_i), 64'd0);
        after_reset = 1'b0;
      end
      if (req_valid_i && req_ready_i) begin
        cur_req     = req_i;
        cur_id      = test_id_i;
        cur_exp_rd  = exp_rd_i;
        cur_exp_wr  = exp_wr_i;
        rd_bursts   = 0;
        wr_bursts   = 0;
        test_errors = 0;
      end
      if (mem_req_valid_i && mem_req_ready_i) begin
        if (mem_req_i.we) begin
          wr_bursts++;
          wb_base = {mem_req_i.addr, 6'b000000};
          wb_beat = 0;
        end else begin
          rd_bursts++;
        end
      end
      // a written-back line must carry every byte written to it so far.
      if (mem_wvalid_i && mem_wready_i) begin
        check_value("mem_wdata_o", mem_wdata_i,
                    expected_data(wb_base + addr_t'(8 * wb_beat), 2'd3));
        wb_beat++;
      end
      if (rsp_valid_i && rsp_ready_i) begin
        finish_test();
      end
    end
  end

endmodule

//--- cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl
  import cache_cfg_pkg::*;
  import mem_bus_pkg::*;
#(
  parameter  int NUM_WAYS = 2,
  localparam int WAY_W    = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1
) (
  input  logic                    clk,
  input  logic                    rst,
  input  cpu_req_t                req_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  output cpu_rsp_t                rsp_o,
  output logic                    rsp_valid_o,
  input  logic                    rsp_ready_i,
  output mem_req_t                mem_req_o,
  output logic                    mem_req_valid_o,
  input  logic                    mem_req_ready_i,
  output word_t                   mem_wdata_o,
  output logic                    mem_wvalid_o,
  input  logic                    mem_wready_i,
  input  word_t                   mem_rdata_i,
  input  logic                    mem_rvalid_i,
  output logic                    mem_rready_o,
  output tag_t                    lookup_tag_o,
  output index_t                  lookup_index_o,
  output word_sel_t               lookup_word_o,
  output size_t                   lookup_size_o,
  output byte_off_t               lookup_off_o,
  output way_cmd_t [NUM_WAYS-1:0] cmd_o,
  input  logic                    hit_i,
  input  logic     [WAY_W-1:0]    hit_way_i,
  input  way_stat_t               victim_stat_i,
  input  word_t                   victim_word_i,
  input  word_t                   rdata_i,
  output logic     [WAY_W-1:0]    victim_way_o
);

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    RESP,
    WB_REQ,
    WB_DATA,
    RF_REQ,
    RF_DATA
  } state_e;

  state_e           state_q;
  state_e           state_d;
  cpu_req_t         req_q;
  cpu_rsp_t         rsp_q;
  logic             rsp_valid_q;
  beat_cnt_t        beat_q;
  logic [WAY_W-1:0] rr_q [NUM_SETS];

  tag_t      req_tag;
  index_t    req_index;
  word_sel_t req_word;
  byte_off_t req_off;
  strb_t     wr_strb;
  word_t     wr_data;
  logic      victim_dirty;
  logic      beat_last;
  logic      req_fire;
  logic      rsp_fire;
  logic      mreq_fire;
  logic      w_fire;
  logic      r_fire;

  assign {req_tag, req_index, req_word, req_off} = req_q.addr;

  assign req_ready_o  = (state_q == IDLE);
  assign req_fire     = req_valid_i && req_ready_o;
  assign rsp_fire     = rsp_valid_o && rsp_ready_i;
  assign mreq_fire    = mem_req_valid_o && mem_req_ready_i;
  assign w_fire       = mem_wvalid_o && mem_wready_i;
  assign r_fire       = mem_rvalid_i && mem_rready_o;
  assign beat_last    = (beat_q == beat_cnt_t'(BEATS_PER_LINE - 1));
  assign victim_dirty = victim_stat_i.valid && victim_stat_i.dirty;

  // store data arrives in the low bytes and moves up to its byte lanes.
  assign wr_strb = size_strb(req_q.size) << req_off;
  assign wr_data = req_q.wdata << {req_off, 3'b000};

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (req_fire) state_d = LOOKUP;
      LOOKUP: begin
        if (hit_i) begin
          state_d = RESP;
        end else if (victim_dirty) begin
          state_d = WB_REQ;
        end else begin
          state_d = RF_REQ;
        end
      end
      RESP:    if (rsp_fire) state_d = IDLE;
      WB_REQ:  if (mreq_fire) state_d = WB_DATA;
      WB_DATA: if (w_fire && beat_last) state_d = RF_REQ;
      RF_REQ:  if (mreq_fire) state_d = RF_DATA;
      // the refilled line is looked up again and then hits.
      RF_DATA: if (r_fire && beat_last) state_d = LOOKUP;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= IDLE;
      rsp_valid_q <= 1'b0;
      beat_q      <= '0;
      for (int s = 0; s < NUM_SETS; s++) begin
        rr_q[s] <= '0;
      end
    end else begin
      state_q <= state_d;
      if (state_q == LOOKUP && hit_i) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_fire) begin
        rsp_valid_q <= 1'b0;
      end
      if (w_fire || r_fire) begin
        beat_q <= beat_q + beat_cnt_t'(1);
      end
      if (r_fire && beat_last) begin
        rr_q[req_index] <= (rr_q[req_index] == WAY_W'(NUM_WAYS - 1)) ?
                           '0 : rr_q[req_index] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      req_q <= req_i;
    end
    if (state_q == LOOKUP && hit_i) begin
      rsp_q.rdata <= rdata_i;
    end
  end

  assign rsp_o       = rsp_q;
  assign rsp_valid_o = rsp_valid_q;

  assign mem_req_valid_o = (state_q == WB_REQ) || (state_q == RF_REQ);
  assign mem_req_o.we    = (state_q == WB_REQ);
  assign mem_req_o.addr  = (state_q == WB_REQ) ? {victim_stat_i.tag, req_index} :
                                                 {req_tag, req_index};
  assign mem_wdata_o     = victim_word_i;
  assign mem_wvalid_o    = (state_q == WB_DATA);
  assign mem_rready_o    = (state_q == RF_DATA);

  assign lookup_tag_o   = req_tag;
  assign lookup_index_o = req_index;
  assign lookup_word_o  = (state_q == WB_DATA) ? beat_q : req_word;
  assign lookup_size_o  = req_q.size;
  assign lookup_off_o   = req_off;
  assign victim_way_o   = rr_q[req_index];

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      cmd_o[w]       = '0;
      cmd_o[w].index = req_index;
      if (state_q == LOOKUP && hit_i && req_q.we && hit_way_i == WAY_W'(w)) begin
        cmd_o[w].word_sel  = req_word;
        cmd_o[w].strb      = wr_strb;
        cmd_o[w].wdata     = wr_data;
        cmd_o[w].set_dirty = 1'b1;
      end
      if (victim_way_o == WAY_W'(w)) begin
        cmd_o[w].install = (state_q == RF_REQ) && mreq_fire;
        if (r_fire) begin
          cmd_o[w].word_sel = beat_q;
          cmd_o[w].strb     = '1;
          cmd_o[w].wdata    = mem_rdata_i;
          cmd_o[w].validate = beat_last;
        end
      end
    end
  end

  // the victim tag feeds the write-back address and must not move under it.
  a_mem_req_stable: assert property (
    @(posedge clk) disable iff (rst)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o)
  ) else $error("memory request changed while waiting for ready");

  a_rsp_in_resp: assert property (
    @(posedge clk) disable iff (rst)
    rsp_valid_o |-> state_q == RESP
  ) else $error("response valid outside RESP");

endmodule

//--- cache_top.sv
`timescale 1ns/1ps

module cache_top
  import cache_cfg_pkg::*;
  import mem_bus_pkg::*;
#(
  parameter int NUM_WAYS = 2
) (
  input  logic     clk,
  input  logic     rst,
  input  cpu_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  output cpu_rsp_t rsp_o,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,
  output mem_req_t mem_req_o,
  output logic     mem_req_valid_o,
  input  logic     mem_req_ready_i,
  output word_t    mem_wdata_o,
  output logic     mem_wvalid_o,
  input  logic     mem_wready_i,
  input  word_t    mem_rdata_i,
  input  logic     mem_rvalid_i,
  output logic     mem_rready_o
);

  localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

  tag_t                     lookup_tag;
  index_t                   lookup_index;
  word_sel_t                lookup_word;
  size_t                    lookup_size;
  byte_off_t                lookup_off;
  way_cmd_t  [NUM_WAYS-1:0] way_cmd;
  way_stat_t [NUM_WAYS-1:0] way_stat;
  word_t     [NUM_WAYS-1:0] way_word;
  logic                     hit;
  logic      [WAY_W-1:0]    hit_way;
  logic      [WAY_W-1:0]    victim_way;
  way_stat_t                victim_stat;
  word_t                    victim_word;
  word_t                    rdata;

  cache_ctrl #(
    .NUM_WAYS(NUM_WAYS)
  ) u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .req_i          (req_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .rsp_o          (rsp_o),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i),
    .mem_req_o      (mem_req_o),
    .mem_req_valid_o(mem_req_valid_o),
    .mem_req_ready_i(mem_req_ready_i),
    .mem_wdata_o    (mem_wdata_o),
    .mem_wvalid_o   (mem_wvalid_o),
    .mem_wready_i   (mem_wready_i),
    .mem_rdata_i    (mem_rdata_i),
    .mem_rvalid_i   (mem_rvalid_i),
    .mem_rready_o   (mem_rready_o),
    .lookup_tag_o   (lookup_tag),
    .lookup_index_o (lookup_index),
    .lookup_word_o  (lookup_word),
    .lookup_size_o  (lookup_size),
    .lookup_off_o   (lookup_off),
    .cmd_o          (way_cmd),
    .hit_i          (hit),
    .hit_way_i      (hit_way),
    .victim_stat_i  (victim_stat),
    .victim_word_i  (victim_word),
    .rdata_i        (rdata),
    .victim_way_o   (victim_way)
  );

  // all ways see the same lookup address and differ only in their command.
  for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
    cache_way u_way (
      .clk           (clk),
      .rst           (rst),
      .lookup_tag_i  (lookup_tag),
      .lookup_index_i(lookup_index),
      .lookup_word_i (lookup_word),
      .cmd_i         (way_cmd[g]),
      .stat_o        (way_stat[g]),
      .rdata_o       (way_word[g])
    );
  end

  hit_select #(
    .NUM_WAYS(NUM_WAYS)
  ) u_hit_select (
    .stat_i       (way_stat),
    .word_i       (way_word),
    .victim_way_i (victim_way),
    .size_i       (lookup_size),
    .byte_off_i   (lookup_off),
    .hit_o        (hit),
    .hit_way_o    (hit_way),
    .victim_stat_o(victim_stat),
    .victim_word_o(victim_word),
    .rdata_o      (rdata)
  );

endmodule

//--- cache_way.sv
`timescale 1ns/1ps

module cache_way
  import cache_cfg_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  tag_t      lookup_tag_i,
  input  index_t    lookup_index_i,
  input  word_sel_t lookup_word_i,
  input  way_cmd_t  cmd_i,
  output way_stat_t stat_o,
  output word_t     rdata_o
);

  tag_t                tag_q [NUM_SETS];
  logic [NUM_SETS-1:0] valid_q;
  logic [NUM_SETS-1:0] dirty_q;
  word_t               data_q [NUM_SETS][WORDS_PER_LINE];

  // the read side is purely combinational on the lookup address.
  assign stat_o.valid = valid_q[lookup_index_i];
  assign stat_o.dirty = dirty_q[lookup_index_i];
  assign stat_o.tag   = tag_q[lookup_index_i];
  assign stat_o.hit   = valid_q[lookup_index_i] &&
                        (tag_q[lookup_index_i] == lookup_tag_i);
  assign rdata_o      = data_q[lookup_index_i][lookup_word_i];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (cmd_i.install) begin
        valid_q[cmd_i.index] <= 1'b0;
        dirty_q[cmd_i.index] <= 1'b0;
      end
      if (cmd_i.validate) begin
        valid_q[cmd_i.index] <= 1'b1;
      end
      if (cmd_i.set_dirty) begin
        dirty_q[cmd_i.index] <= 1'b1;
      end
    end
  end

  // the new tag comes from the lookup port, which carries the requested tag.
  always_ff @(posedge clk) begin
    if (cmd_i.install) begin
      tag_q[cmd_i.index] <= lookup_tag_i;
    end
  end

  always_ff @(posedge clk) begin
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (cmd_i.strb[b]) begin
        data_q[cmd_i.index][cmd_i.word_sel][8*b +: 8] <= cmd_i.wdata[8*b +: 8];
      end
    end
  end

  // a line is installed at the refill request and validated on its last beat.
  a_install_validate: assert property (
    @(posedge clk) disable iff (rst)
    !(cmd_i.install && cmd_i.validate)
  ) else $error("install and validate active in the same cycle");

endmodule

//--- compile.f
cache_cfg_pkg.sv
mem_bus_pkg.sv
cache_way.sv
hit_select.sv
cache_ctrl.sv
cache_top.sv
cache_checker.sv
tb_cache_top.sv

//--- hit_select.sv
`timescale 1ns/1ps

module hit_select
  import cache_cfg_pkg::*;
#(
  parameter  int NUM_WAYS = 2,
  localparam int WAY_W    = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1
) (
  input  way_stat_t [NUM_WAYS-1:0] stat_i,
  input  word_t     [NUM_WAYS-1:0] word_i,
  input  logic      [WAY_W-1:0]    victim_way_i,
  input  size_t                    size_i,
  input  byte_off_t                byte_off_i,
  output logic                     hit_o,
  output logic      [WAY_W-1:0]    hit_way_o,
  output way_stat_t                victim_stat_o,
  output word_t                    victim_word_o,
  output word_t                    rdata_o
);

  logic [NUM_WAYS-1:0] hit_vec;
  word_t               hit_word;
  word_t               shifted;

  always_comb begin
    hit_way_o = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_vec[w] = stat_i[w].hit;
      if (stat_i[w].hit) begin
        hit_way_o = WAY_W'(w);
      end
    end
  end

  assign hit_o    = |hit_vec;
  assign hit_word = word_i[hit_way_o];

  // the addressed bytes move down to bit 0, the rest is cleared.
  assign shifted = hit_word >> {byte_off_i, 3'b000};
  assign rdata_o = shifted & strb_to_mask(size_strb(size_i));

  // write-back reads the victim through the same lookup address.
  assign victim_stat_o = stat_i[victim_way_i];
  assign victim_word_o = word_i[victim_way_i];

  // two ways can only match if a refill installed a tag already present.
  a_one_hit: assert final ($isunknown(hit_vec) || $onehot0(hit_vec))
    else $error("more than one way hits: %b", hit_vec);

endmodule

//--- mem_bus_pkg.sv
package mem_bus_pkg;

  // a line is 64 bytes, so the low six address bits are always zero.
  localparam int LINE_ADDR_BITS = 26;
  localparam int BEATS_PER_LINE = 8;

  typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;
  typedef logic [2:0]                beat_cnt_t;

  typedef struct packed {
    line_addr_t addr;
    logic       we;
  } mem_req_t;

endpackage

//--- tb_cache_top.sv
`timescale 1ns/1ps

module tb_cache_top
  import cache_cfg_pkg::*;
  import mem_bus_pkg::*;
;

  localparam int CLK_PERIOD      = 4;
  localparam int NUM_TESTS       = 17;
  localparam int NUM_PASSES      = 2;
  localparam int WATCHDOG_CYCLES = NUM_PASSES * NUM_TESTS * 200;

  typedef struct packed {
    logic [7:0] id;
    addr_t      addr;
    logic       we;
    size_t      size;
    word_t      wdata;
    logic [3:0] exp_rd;
    logic [3:0] exp_wr;
  } test_entry_t;

  logic     clk;
  logic     rst;
  cpu_req_t req_i;
  logic     req_valid_i;
  logic     req_ready_o;
  cpu_rsp_t rsp_o;
  logic     rsp_valid_o;
  logic     rsp_ready_i;
  mem_req_t mem_req_o;
  logic     mem_req_valid_o;
  logic     mem_req_ready_i;
  word_t    mem_wdata_o;
  logic     mem_wvalid_o;
  logic     mem_wready_i;
  word_t    mem_rdata_i;
  logic     mem_rvalid_i;
  logic     mem_rready_o;

  logic        stall_en;
  test_entry_t cur_test;
  int          tests_run;
  int          errors;
  addr_t       burst_base;
  int          beat;
  int          rd_left;
  word_t       mem_store [addr_t];

  // set 4 holds the partial-write line, set 3 is filled with three lines 0x800 apart.
  test_entry_t tests [NUM_TESTS] = '{
    '{8'd1,  32'h0000_4108, 1'b0, 2'd3, 64'h0,                   4'd1, 4'd0},
    '{8'd2,  32'h0000_4110, 1'b0, 2'd2, 64'h0,                   4'd0, 4'd0},
    '{8'd3,  32'h0000_4119, 1'b1, 2'd0, 64'h0000_0000_0000_00a5, 4'd0, 4'd0},
    '{8'd4,  32'h0000_411a, 1'b1, 2'd1, 64'h0000_0000_0000_beef, 4'd0, 4'd0},
    '{8'd5,  32'h0000_411c, 1'b1, 2'd2, 64'h0000_0000_1234_5678, 4'd0, 4'd0},
    '{8'd6,  32'h0000_4120, 1'b1, 2'd3, 64'h0123_4567_89ab_cdef, 4'd0, 4'd0},
    '{8'd7,  32'h0000_4118, 1'b0, 2'd3, 64'h0,                   4'd0, 4'd0},
    '{8'd8,  32'h0000_411a, 1'b0, 2'd1, 64'h0,                   4'd0, 4'd0},
    '{8'd9,  32'h0000_411c, 1'b0, 2'd2, 64'h0,                   4'd0, 4'd0},
    '{8'd10, 32'h0000_4119, 1'b0, 2'd0, 64'h0,                   4'd0, 4'd0},
    '{8'd11, 32'h0000_4124, 1'b0, 2'd2, 64'h0,                   4'd0, 4'd0},
    '{8'd12, 32'h0000_4122, 1'b0, 2'd1, 64'h0,                   4'd0, 4'd0},
    '{8'd13, 32'h0000_20c8, 1'b1, 2'd3, 64'hdead_beef_cafe_f00d, 4'd1, 4'd0},
    '{8'd14, 32'h0000_28c0, 1'b0, 2'd3, 64'h0,                   4'd1, 4'd0},
    '{8'd15, 32'h0000_30d0, 1'b0, 2'd3, 64'h0,                   4'd1, 4'd1},
    '{8'd16, 32'h0000_20c8, 1'b0, 2'd3, 64'h0,                   4'd1, 4'd0},
    '{8'd17, 32'h0000_20cc, 1'b0, 2'd2, 64'h0,                   4'd0, 4'd0}
  };

  always #(CLK_PERIOD / 2) clk = ~clk;

  // untouched memory holds the byte address of each word next to its inverse.
  function automatic word_t pattern_word(addr_t a);
    return {a, ~a};
  endfunction

  function automatic word_t read_word(addr_t a);
    return mem_store.exists(a) ? mem_store[a] : pattern_word(a);
  endfunction

  function automatic logic random_ready();
    return !stall_en || (($urandom % 4) != 0);
  endfunction

  task automatic apply_reset();
    rst <= 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic run_test(input test_entry_t t);
    @(posedge clk);
    cur_test    <= t;
    req_i       <= '{addr: t.addr, we: t.we, size: t.size, wdata: t.wdata};
    req_valid_i <= 1'b1;
    @(posedge clk);
    while (!req_ready_o) @(posedge clk);
    req_valid_i <= 1'b0;
    @(posedge clk);
    while (!(rsp_valid_o && rsp_ready_i)) @(posedge clk);
  endtask

  always @(posedge clk) begin
    rsp_ready_i <= random_ready();
  end

  // the memory model serves one burst at a time.
  always @(posedge clk) begin
    if (rst) begin
      mem_req_ready_i <= 1'b0;
      mem_wready_i    <= 1'b0;
      mem_rvalid_i    <= 1'b0;
      mem_rdata_i     <= '0;
      mem_store.delete();
      rd_left = 0;
      beat    = 0;
    end else begin
      if (mem_req_valid_o && mem_req_ready_i) begin
        burst_base = {mem_req_o.addr, 6'b000000};
        beat       = 0;
        if (!mem_req_o.we) begin
          rd_left = BEATS_PER_LINE;
        end
      end
      if (mem_wvalid_o && mem_wready_i) begin
        mem_store[burst_base + addr_t'(8 * beat)] = mem_wdata_o;
        beat++;
      end
      if (mem_rvalid_i && mem_rready_o) begin
        beat++;
        rd_left--;
      end
      mem_req_ready_i <= random_ready();
      mem_wready_i    <= random_ready();
      if (!(mem_rvalid_i && !mem_rready_o)) begin
        if (rd_left > 0 && random_ready()) begin
          mem_rvalid_i <= 1'b1;
          mem_rdata_i  <= read_word(burst_base + addr_t'(8 * beat));
        end else begin
          mem_rvalid_i <= 1'b0;
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    clk             = 1'b0;
    rst             = 1'b1;
    req_i           = '0;
    req_valid_i     = 1'b0;
    rsp_ready_i     = 1'b0;
    mem_req_ready_i = 1'b0;
    mem_wready_i    = 1'b0;
    mem_rvalid_i    = 1'b0;
    mem_rdata_i     = '0;
    stall_en        = 1'b0;
    cur_test        = '0;
    void'($urandom(88303));
    // the second pass repeats the table from reset with random stalls.
    for (int p = 0; p < NUM_PASSES; p++) begin
      stall_en = (p != 0);
      apply_reset();
      for (int i = 0; i < NUM_TESTS; i++) begin
        run_test(tests[i]);
      end
    end
    repeat (2) @(posedge clk);
    if (tests_run != NUM_PASSES * NUM_TESTS) begin
      $display("expected %0d completed tests but saw %0d", NUM_PASSES * NUM_TESTS,
               tests_run);
    end
    $display("tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0 && tests_run == NUM_PASSES * NUM_TESTS) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  cache_top #(
    .NUM_WAYS(2)
  ) u_dut (
    .clk            (clk),
    .rst            (rst),
    .req_i          (req_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .rsp_o          (rsp_o),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i),
    .mem_req_o      (mem_req_o),
    .mem_req_valid_o(mem_req_valid_o),
    .mem_req_ready_i(mem_req_ready_i),
    .mem_wdata_o    (mem_wdata_o),
    .mem_wvalid_o   (mem_wvalid_o),
    .mem_wready_i   (mem_wready_i),
    .mem_rdata_i    (mem_rdata_i),
    .mem_rvalid_i   (mem_rvalid_i),
    .mem_rready_o   (mem_rready_o)
  );

  cache_checker u_checker (
    .clk            (clk),
    .rst            (rst),
    .req_i          (req_i),
    .req_valid_i    (req_valid_i),
    .req_ready_i    (req_ready_o),
    .rsp_i          (rsp_o),
    .rsp_valid_i    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i),
    .mem_req_i      (mem_req_o),
    .mem_req_valid_i(mem_req_valid_o),
    .mem_req_ready_i(mem_req_ready_i),
    .mem_wdata_i    (mem_wdata_o),
    .mem_wvalid_i   (mem_wvalid_o),
    .mem_wready_i   (mem_wready_i),
    .mem_rready_i   (mem_rready_o),
    .test_id_i      (int'(cur_test.id)),
    .exp_rd_i       (int'(cur_test.exp_rd)),
    .exp_wr_i       (int'(cur_test.exp_wr)),
    .tests_o        (tests_run),
    .errors_o       (errors)
  );

endmodule
